// ==== hdl/video_pkg.sv ====
package video_pkg;

   // screen coordinates and timing values
   typedef logic [11:0] coord_t;

   // character code, also one glyph row
   typedef logic [7:0] char_t;

   // address into the shared text and font memory
   typedef logic [11:0] mem_addr_t;

   typedef logic [4:0] red_t;
   typedef logic [5:0] green_t;
   typedef logic [4:0] blue_t;

   localparam int GLYPH_W = 8;
   localparam int GLYPH_H = 8;

   // text area sits above the font at code * 8 + glyph row
   localparam mem_addr_t TEXT_BASE = 12'd2048;

   localparam red_t   FG_R = 5'd19;
   localparam green_t FG_G = 6'd39;
   localparam blue_t  FG_B = 5'd19;

   localparam red_t   BG_R = 5'd0;
   localparam green_t BG_G = 6'd0;
   localparam blue_t  BG_B = 5'd0;

   localparam red_t   BORDER_R = 5'd4;
   localparam green_t BORDER_G = 6'd8;
   localparam blue_t  BORDER_B = 5'd6;

   typedef enum logic [2:0] {
      IDLE,
      TEXT_REQ,
      TEXT_WAIT,
      GLYPH_REQ,
      GLYPH_WAIT
   } fetch_state_t;

endpackage

// ==== hdl/video_timing.sv ====
`timescale 1ns/1ns

module video_timing import video_pkg::*; #(
   parameter int H_TOTAL    = 120,
   parameter int H_SYNC     = 9,
   parameter int H_DE_START = 16,
   parameter int H_DE_END   = 112,
   parameter int H_PF_START = 32,
   parameter int COLS       = 8,
   parameter int V_TOTAL    = 40,
   parameter int V_SYNC     = 3,
   parameter int V_DE_START = 6,
   parameter int V_DE_END   = 38,
   parameter int V_PF_START = 14,
   parameter int V_PF_END   = 30
) (
   input  logic   vga_clk,
   input  logic   reset_n,
   output coord_t x,
   output coord_t y,
   output logic   hsync_raw,
   output logic   vsync_raw,
   output logic   de,
   output logic   pf,
   output logic   line_start,
   output coord_t fetch_row
);

   localparam int H_PF_END = H_PF_START + COLS * GLYPH_W;

   coord_t next_y;
   logic   h_de;
   logic   v_de;
   logic   h_pf;
   logic   v_pf;

   // both counters start at 1
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         x <= coord_t'(1);
         y <= coord_t'(1);
      end else if (x == coord_t'(H_TOTAL)) begin
         x <= coord_t'(1);
         y <= next_y;
      end else begin
         x <= x + coord_t'(1);
      end
   end

   assign next_y = (y == coord_t'(V_TOTAL)) ? coord_t'(1) : y + coord_t'(1);

   // sync asserted low from 1 to SYNC - 1
   assign hsync_raw = !(x < coord_t'(H_SYNC));
   assign vsync_raw = !(y < coord_t'(V_SYNC));

   assign h_de = (x >= coord_t'(H_DE_START)) && (x < coord_t'(H_DE_END));
   assign v_de = (y >= coord_t'(V_DE_START)) && (y < coord_t'(V_DE_END));
   assign h_pf = (x >= coord_t'(H_PF_START)) && (x < coord_t'(H_PF_END));
   assign v_pf = (y >= coord_t'(V_PF_START)) && (y < coord_t'(V_PF_END));

   assign de = h_de && v_de;
   assign pf = h_pf && v_pf;

   // strobe the fetcher one line ahead of every playfield line
   assign line_start = (x == coord_t'(1))
                    && (next_y >= coord_t'(V_PF_START))
                    && (next_y < coord_t'(V_PF_END));

   assign fetch_row = next_y - coord_t'(V_PF_START);

endmodule

// ==== hdl/glyph_fetch.sv ====
`timescale 1ns/1ns

module glyph_fetch import video_pkg::*; #(
   parameter  int COLS   = 8,
   localparam int ADDR_W = $clog2(COLS * GLYPH_W)
) (
   input  logic              vga_clk,
   input  logic              reset_n,
   input  logic              line_start,
   input  coord_t            fetch_row,
   output logic              wb_cyc,
   output logic              wb_stb,
   output mem_addr_t         wb_adr,
   input  char_t             wb_dat_r,
   input  logic              wb_ack,
   output logic [1:0]        wr_en,
   output logic [ADDR_W-1:0] wr_addr,
   output logic              wr_bit
);

   localparam int COL_W     = (COLS > 1) ? $clog2(COLS) : 1;
   localparam int ROW_SHIFT = $clog2(GLYPH_H);
   localparam logic [COL_W-1:0] LAST_COL = COL_W'(COLS - 1);

   fetch_state_t         state;
   char_t                codes [COLS];
   logic [COL_W-1:0]     col;
   coord_t               char_row;
   logic [ROW_SHIFT-1:0] glyph_row;
   logic                 buf_sel;
   char_t                pix_sr;
   logic [3:0]           bits_left;
   mem_addr_t            text_adr;
   mem_addr_t            glyph_adr;

   assign text_adr  = TEXT_BASE + mem_addr_t'(char_row * COLS) + mem_addr_t'(col);
   assign glyph_adr = mem_addr_t'({codes[col], glyph_row});

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         state     <= IDLE;
         wb_cyc    <= 1'b0;
         wb_stb    <= 1'b0;
         col       <= '0;
         buf_sel   <= 1'b0;
         bits_left <= '0;
         wr_addr   <= '0;
      end else begin
         // shift the current glyph row out one pixel per clock
         if (bits_left != 4'd0) begin
            pix_sr    <= pix_sr << 1;
            bits_left <= bits_left - 4'd1;
            wr_addr   <= wr_addr + 1'b1;
         end

         if (line_start) begin
            // first row of a frame always lands in buffer 0
            buf_sel   <= (fetch_row == '0) ? 1'b0 : ~buf_sel;
            char_row  <= fetch_row >> ROW_SHIFT;
            glyph_row <= fetch_row[ROW_SHIFT-1:0];
            col       <= '0;
            wr_addr   <= '0;
            bits_left <= '0;
            wb_cyc    <= 1'b0;
            wb_stb    <= 1'b0;
            // codes are only fetched on the top glyph row of a character row
            state     <= (fetch_row[ROW_SHIFT-1:0] == '0) ? TEXT_REQ : GLYPH_REQ;
         end else begin
            case (state)
               TEXT_REQ: begin
                  wb_cyc <= 1'b1;
                  wb_stb <= 1'b1;
                  wb_adr <= text_adr;
                  state  <= TEXT_WAIT;
               end
               TEXT_WAIT: begin
                  if (wb_ack) begin
                     codes[col] <= wb_dat_r;
                     wb_stb     <= 1'b0;
                     col        <= (col == LAST_COL) ? '0 : col + 1'b1;
                     state      <= (col == LAST_COL) ? GLYPH_REQ : TEXT_REQ;
                  end
               end
               GLYPH_REQ: begin
                  // issue early enough that the data arrives with the last bit
                  if (bits_left <= 4'd3) begin
                     wb_cyc <= 1'b1;
                     wb_stb <= 1'b1;
                     wb_adr <= glyph_adr;
                     state  <= GLYPH_WAIT;
                  end
               end
               GLYPH_WAIT: begin
                  if (wb_ack) begin
                     pix_sr    <= wb_dat_r;
                     bits_left <= 4'(GLYPH_W);
                     wb_stb    <= 1'b0;
                     if (col == LAST_COL) begin
                        wb_cyc <= 1'b0;
                        state  <= IDLE;
                     end else begin
                        col   <= col + 1'b1;
                        state <= GLYPH_REQ;
                     end
                  end
               end
               default: begin
                  wb_cyc <= 1'b0;
                  wb_stb <= 1'b0;
               end
            endcase
         end
      end
   end

   // msb is the leftmost pixel
   assign wr_bit = pix_sr[GLYPH_W-1];
   assign wr_en  = (bits_left == 4'd0) ? 2'b00 : (buf_sel ? 2'b10 : 2'b01);

endmodule

// ==== hdl/line_buffer.sv ====
`timescale 1ns/1ns

module line_buffer import video_pkg::*; #(
   parameter  int COLS   = 8,
   localparam int ADDR_W = $clog2(COLS * GLYPH_W)
) (
   input  logic              vga_clk,
   input  logic              wr_en,
   input  logic [ADDR_W-1:0] wr_addr,
   input  logic              wr_bit,
   input  logic [ADDR_W-1:0] rd_addr,
   output logic              rd_bit
);

   logic pixels [COLS * GLYPH_W];

   always_ff @(posedge vga_clk) begin
      if (wr_en) begin
         pixels[wr_addr] <= wr_bit;
      end
      // registered read with the address issued a clock early
      rd_bit <= pixels[rd_addr];
   end

endmodule

// ==== hdl/pixel_out.sv ====
`timescale 1ns/1ns

module pixel_out import video_pkg::*; #(
   parameter  int H_PF_START = 32,
   parameter  int V_PF_START = 14,
   parameter  int V_TOTAL    = 40,
   parameter  int COLS       = 8,
   localparam int ADDR_W     = $clog2(COLS * GLYPH_W)
) (
   input  logic              vga_clk,
   input  logic              reset_n,
   input  coord_t            x,
   input  coord_t            y,
   input  logic              hsync_raw,
   input  logic              vsync_raw,
   input  logic              de,
   input  logic              pf,
   input  logic              line_start,
   output logic [ADDR_W-1:0] rd_addr,
   input  logic [1:0]        rd_bit,
   output logic              vga_hs,
   output logic              vga_vs,
   output red_t              vga_r,
   output green_t            vga_g,
   output blue_t             vga_b
);

   // line on which the first playfield row gets fetched
   localparam coord_t PRE_PF_LINE = (V_PF_START == 1) ? coord_t'(V_TOTAL)
                                                     : coord_t'(V_PF_START - 1);

   logic   fill_sel;
   logic   disp_sel;
   logic   pix;
   coord_t rd_x;
   red_t   r_next;
   green_t g_next;
   blue_t  b_next;

   // read one position ahead to cover the buffer read latency
   assign rd_x    = x + coord_t'(1) - coord_t'(H_PF_START);
   assign rd_addr = rd_x[ADDR_W-1:0];
   assign pix     = rd_bit[disp_sel];

   always_comb begin
      if (!de) begin
         r_next = '0;
         g_next = '0;
         b_next = '0;
      end else if (!pf) begin
         r_next = BORDER_R;
         g_next = BORDER_G;
         b_next = BORDER_B;
      end else begin
         r_next = pix ? FG_R : BG_R;
         g_next = pix ? FG_G : BG_G;
         b_next = pix ? FG_B : BG_B;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         fill_sel <= 1'b0;
         disp_sel <= 1'b0;
         vga_hs   <= 1'b1;
         vga_vs   <= 1'b1;
         vga_r    <= '0;
         vga_g    <= '0;
         vga_b    <= '0;
      end else begin
         // track the buffer the fetcher is filling
         if (line_start) begin
            fill_sel <= (y == PRE_PF_LINE) ? 1'b0 : ~fill_sel;
         end
         // show what was filled during the previous line
         if (x == coord_t'(1)) begin
            disp_sel <= fill_sel;
         end
         vga_hs <= hsync_raw;
         vga_vs <= vsync_raw;
         vga_r  <= r_next;
         vga_g  <= g_next;
         vga_b  <= b_next;
      end
   end

endmodule

// ==== hdl/text_ram.sv ====
`timescale 1ns/1ns

module text_ram import video_pkg::*; #(
   parameter int TEXT_BYTES = 16
) (
   input  logic      vga_clk,
   input  logic      reset_n,
   input  logic      host_we,
   input  mem_addr_t host_addr,
   input  char_t     host_data,
   input  logic      wb_cyc,
   input  logic      wb_stb,
   input  mem_addr_t wb_adr,
   output char_t     wb_dat_r,
   output logic      wb_ack
);

   localparam int MEM_SIZE = int'(TEXT_BASE) + TEXT_BYTES;

   // font glyph rows followed by the character codes
   char_t mem [MEM_SIZE];

   // host port owns the only write path
   always_ff @(posedge vga_clk) begin
      if (host_we && (int'(host_addr) < MEM_SIZE)) begin
         mem[host_addr] <= host_data;
      end
   end

   always_ff @(posedge vga_clk) begin
      if (wb_cyc && wb_stb) begin
         wb_dat_r <= mem[wb_adr];
      end
   end

   // ack on the second cycle of stb for one wait state
   always_ff @(posedge vga_clk) begin
      if (!reset_n) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= wb_cyc && wb_stb && !wb_ack;
      end
   end

endmodule

// ==== hdl/text_display.sv ====
`timescale 1ns/1ns

module text_display import video_pkg::*; #(
   parameter int H_TOTAL    = 120,
   parameter int H_SYNC     = 9,
   parameter int H_DE_START = 16,
   parameter int H_DE_END   = 112,
   parameter int H_PF_START = 32,
   parameter int COLS       = 8,
   parameter int V_TOTAL    = 40,
   parameter int V_SYNC     = 3,
   parameter int V_DE_START = 6,
   parameter int V_DE_END   = 38,
   parameter int V_PF_START = 14,
   parameter int V_PF_END   = 30
) (
   input  logic      vga_clk,
   input  logic      reset_n,
   input  logic      host_we,
   input  mem_addr_t host_addr,
   input  char_t     host_data,
   output logic      vga_hs,
   output logic      vga_vs,
   output red_t      vga_r,
   output green_t    vga_g,
   output blue_t     vga_b
);

   localparam int ADDR_W     = $clog2(COLS * GLYPH_W);
   localparam int TEXT_BYTES = COLS * ((V_PF_END - V_PF_START) / GLYPH_H);

   coord_t            x;
   coord_t            y;
   coord_t            fetch_row;
   logic              hsync_raw;
   logic              vsync_raw;
   logic              de;
   logic              pf;
   logic              line_start;
   logic              wb_cyc;
   logic              wb_stb;
   mem_addr_t         wb_adr;
   char_t             wb_dat_r;
   logic              wb_ack;
   logic [1:0]        wr_en;
   logic [ADDR_W-1:0] wr_addr;
   logic              wr_bit;
   logic [ADDR_W-1:0] rd_addr;
   logic [1:0]        rd_bit;

   video_timing #(
      .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC), .H_DE_START(H_DE_START),
      .H_DE_END(H_DE_END), .H_PF_START(H_PF_START), .COLS(COLS),
      .V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .V_DE_START(V_DE_START),
      .V_DE_END(V_DE_END), .V_PF_START(V_PF_START), .V_PF_END(V_PF_END)
   ) u_timing (
      .vga_clk, .reset_n, .x, .y, .hsync_raw, .vsync_raw,
      .de, .pf, .line_start, .fetch_row
   );

   glyph_fetch #(.COLS(COLS)) u_fetch (
      .vga_clk, .reset_n, .line_start, .fetch_row,
      .wb_cyc, .wb_stb, .wb_adr, .wb_dat_r, .wb_ack,
      .wr_en, .wr_addr, .wr_bit
   );

   // ping-pong pair with one filled while the other is shown
   for (genvar i = 0; i < 2; i++) begin : g_line_buf
      line_buffer #(.COLS(COLS)) u_line_buf (
         .vga_clk,
         .wr_en(wr_en[i]),
         .wr_addr,
         .wr_bit,
         .rd_addr,
         .rd_bit(rd_bit[i])
      );
   end

   pixel_out #(
      .H_PF_START(H_PF_START), .V_PF_START(V_PF_START),
      .V_TOTAL(V_TOTAL), .COLS(COLS)
   ) u_pixel (
      .vga_clk, .reset_n, .x, .y, .hsync_raw, .vsync_raw, .de, .pf,
      .line_start, .rd_addr, .rd_bit,
      .vga_hs, .vga_vs, .vga_r, .vga_g, .vga_b
   );

   text_ram #(.TEXT_BYTES(TEXT_BYTES)) u_ram (
      .vga_clk, .reset_n, .host_we, .host_addr, .host_data,
      .wb_cyc, .wb_stb, .wb_adr, .wb_dat_r, .wb_ack
   );

endmodule

// ==== bench/text_display_asserts.sv ====
`timescale 1ns/1ns

module text_display_asserts import video_pkg::*; #(
   parameter int H_SYNC = 9
) (
   input logic         vga_clk,
   input logic         reset_n,
   input logic         wb_cyc,
   input logic         wb_stb,
   input mem_addr_t    wb_adr,
   input logic         wb_ack,
   input logic         line_start,
   input fetch_state_t fetch_state,
   input logic         vga_hs
);

   int hs_low;
   int failures = 0;

   // consecutive low cycles of the registered hsync
   always_ff @(posedge vga_clk) begin
      if (!vga_hs) begin
         hs_low <= hs_low + 1;
      end else begin
         hs_low <= 0;
      end
   end

   stb_with_cyc: assert property (@(posedge vga_clk) disable iff (!reset_n)
      wb_stb |-> wb_cyc)
      else begin
         failures++;
         $error("wb_stb high while wb_cyc is low");
      end

   adr_held: assert property (@(posedge vga_clk) disable iff (!reset_n)
      (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr)))
      else begin
         failures++;
         $error("wishbone request changed before ack");
      end

   // a busy fetcher here means the previous line shows a stale buffer
   idle_at_line_start: assert property (@(posedge vga_clk) disable iff (!reset_n)
      line_start |-> (fetch_state == IDLE))
      else begin
         failures++;
         $error("line fetch not finished at the next line start");
      end

   hs_width: assert property (@(posedge vga_clk) disable iff (!reset_n)
      $rose(vga_hs) |-> (hs_low == H_SYNC - 1))
      else begin
         failures++;
         $error("vga_hs low for %0d cycles", hs_low);
      end

endmodule

bind text_display text_display_asserts #(.H_SYNC(H_SYNC)) u_asserts (
   .vga_clk, .reset_n, .wb_cyc, .wb_stb, .wb_adr, .wb_ack, .line_start,
   .fetch_state(u_fetch.state), .vga_hs
);

// ==== bench/text_display_tb.sv ====
`timescale 1ns/1ns

module text_display_tb import video_pkg::*; ();

   localparam int H_TOTAL    = 120;
   localparam int H_SYNC     = 9;
   localparam int H_DE_START = 16;
   localparam int H_DE_END   = 112;
   localparam int H_PF_START = 32;
   localparam int COLS       = 8;
   localparam int V_TOTAL    = 40;
   localparam int V_SYNC     = 3;
   localparam int V_DE_START = 6;
   localparam int V_DE_END   = 38;
   localparam int V_PF_START = 14;
   localparam int V_PF_END   = 30;
   localparam int H_PF_END   = H_PF_START + COLS * GLYPH_W;
   localparam int ROWS       = (V_PF_END - V_PF_START) / GLYPH_H;
   localparam int TEXT_BYTES = COLS * ROWS;
   localparam int FRAME      = H_TOTAL * V_TOTAL;
   localparam int REWRITES   = 3;

   logic      vga_clk   = 1'b0;
   logic      reset_n   = 1'b0;
   logic      host_we   = 1'b0;
   mem_addr_t host_addr = '0;
   char_t     host_data = '0;
   logic      vga_hs;
   logic      vga_vs;
   red_t      vga_r;
   green_t    vga_g;
   blue_t     vga_b;

   // shadow copies of what the host wrote
   char_t font_mem [int'(TEXT_BASE)];
   char_t text_mem [TEXT_BYTES];

   int   errors   = 0;
   int   checks   = 0;
   int   timeouts = 0;
   logic check_en = 1'b0;
   logic synced   = 1'b0;
   logic prev_hs  = 1'b1;
   logic prev_vs  = 1'b1;
   logic hs_fell;
   logic vs_fell;
   int   mx       = 0;
   int   my       = 0;
   int   cyc      = 0;
   int   last_hs  = -1;
   int   last_vs  = -1;

   text_display #(
      .H_TOTAL(H_TOTAL), .H_SYNC(H_SYNC), .H_DE_START(H_DE_START),
      .H_DE_END(H_DE_END), .H_PF_START(H_PF_START), .COLS(COLS),
      .V_TOTAL(V_TOTAL), .V_SYNC(V_SYNC), .V_DE_START(V_DE_START),
      .V_DE_END(V_DE_END), .V_PF_START(V_PF_START), .V_PF_END(V_PF_END)
   ) uut (
      .vga_clk, .reset_n, .host_we, .host_addr, .host_data,
      .vga_hs, .vga_vs, .vga_r, .vga_g, .vga_b
   );

   always #2 vga_clk = ~vga_clk;

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      checks++;
      if (expected !== actual) begin
         errors++;
         $display("CHECK FAILED t=%0t %s expected=%0h actual=%0h",
                  $time, name, expected, actual);
      end
   endtask

   // colour for displayed position (px, py) counted from 1
   function automatic logic [15:0] expected_rgb(input int px, input int py);
      int    cx;
      int    cy;
      char_t code;
      char_t glyph;
      if (px < H_DE_START || px >= H_DE_END || py < V_DE_START || py >= V_DE_END) begin
         return 16'h0000;
      end
      if (px < H_PF_START || px >= H_PF_END || py < V_PF_START || py >= V_PF_END) begin
         return {BORDER_R, BORDER_G, BORDER_B};
      end
      cx    = px - H_PF_START;
      cy    = py - V_PF_START;
      code  = text_mem[(cy / GLYPH_H) * COLS + cx / GLYPH_W];
      glyph = font_mem[int'(code) * GLYPH_H + cy % GLYPH_H];
      if (glyph[GLYPH_W - 1 - cx % GLYPH_W]) begin
         return {FG_R, FG_G, FG_B};
      end
      return {BG_R, BG_G, BG_B};
   endfunction

   // screen position follows the sync falling edges
   always @(negedge vga_clk) begin
      cyc++;
      hs_fell = prev_hs && !vga_hs;
      vs_fell = prev_vs && !vga_vs;
      if (hs_fell) begin
         if (last_hs >= 0) begin
            check_value("hsync period", H_TOTAL, cyc - last_hs);
         end
         last_hs = cyc;
         mx      = 1;
         if (vs_fell) begin
            if (last_vs >= 0) begin
               check_value("vsync period", FRAME, cyc - last_vs);
            end
            last_vs = cyc;
            my      = 1;
            synced  = 1'b1;
         end else begin
            my++;
         end
      end else begin
         mx++;
      end
      if (!synced && !hs_fell) begin
         check_value("vga_hs", 1, vga_hs);
         check_value("vga_vs", 1, vga_vs);
         check_value("vga_rgb", 0, {vga_r, vga_g, vga_b});
      end else if (synced && check_en) begin
         check_value($sformatf("vga_rgb(%0d,%0d)", mx, my), expected_rgb(mx, my),
                     {vga_r, vga_g, vga_b});
      end
      prev_hs = vga_hs;
      prev_vs = vga_vs;
   end

   task automatic host_write(input mem_addr_t addr, input char_t data);
      @(posedge vga_clk);
      host_we   <= 1'b1;
      host_addr <= addr;
      host_data <= data;
      if (addr < TEXT_BASE) begin
         font_mem[addr] = data;
      end else begin
         text_mem[addr - TEXT_BASE] = data;
      end
   endtask

   task automatic host_idle();
      @(posedge vga_clk);
      host_we <= 1'b0;
   endtask

   task automatic wait_vsync_fall();
      int   n;
      logic prev;
      logic fell;
      n    = 0;
      fell = 1'b0;
      @(negedge vga_clk);
      prev = vga_vs;
      while (!fell && timeouts == 0) begin
         @(negedge vga_clk);
         fell = prev && !vga_vs;
         prev = vga_vs;
         n++;
         if (!fell && n > 2 * FRAME) begin
            $display("ERROR: timeout, no vsync falling edge within %0d cycles", 2 * FRAME);
            timeouts++;
         end
      end
   endtask

   // compare every pixel of the frame that starts now
   task automatic check_frame();
      check_en <= 1'b1;
      wait_vsync_fall();
      check_en <= 1'b0;
   endtask

   task automatic run_sequence();
      int row;
      int gap;
      for (int a = 0; a < int'(TEXT_BASE); a++) begin
         host_write(mem_addr_t'(a), char_t'($urandom));
      end
      for (int i = 0; i < TEXT_BYTES; i++) begin
         host_write(TEXT_BASE + mem_addr_t'(i), char_t'($urandom));
      end
      host_idle();
      wait_vsync_fall();
      wait_vsync_fall();
      if (timeouts != 0) begin
         return;
      end
      check_frame();
      for (int n = 0; n < REWRITES; n++) begin
         if (timeouts != 0) begin
            return;
         end
         // rewrite one character row somewhere in the middle of a frame
         gap = 200 + int'($urandom % 3000);
         repeat (gap) @(posedge vga_clk);
         row = int'($urandom % ROWS);
         for (int c = 0; c < COLS; c++) begin
            host_write(TEXT_BASE + mem_addr_t'(row * COLS + c), char_t'($urandom));
         end
         host_idle();
         wait_vsync_fall();
         if (timeouts == 0) begin
            check_frame();
         end
      end
   endtask

   task automatic finish_run();
      int assert_fails;
      assert_fails = uut.u_asserts.failures;
      $display("checks=%0d errors=%0d assert_failures=%0d timeouts=%0d",
               checks, errors, assert_fails, timeouts);
      if (errors == 0 && assert_fails == 0 && timeouts == 0 && checks > 0) begin
         $display("** PASS **");
      end else begin
         $display("** FAIL **");
      end
      $finish;
   endtask

   initial begin
      void'($urandom(32'h6758));
      repeat (10) @(posedge vga_clk);
      reset_n <= 1'b1;
      run_sequence();
      finish_run();
   end

endmodule

// ==== build.f ====
hdl/video_pkg.sv
hdl/video_timing.sv
hdl/glyph_fetch.sv
hdl/line_buffer.sv
hdl/pixel_out.sv
hdl/text_ram.sv
hdl/text_display.sv
bench/text_display_asserts.sv
bench/text_display_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = text_display_tb
FILELIST  = build.f
OBJDIR    = obj_dir
PASS_MSG  = ** PASS **

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	@out=$$(./$(OBJDIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(OBJDIR)
